/* logic/lsq_pkg.sv */
////////////////////
// LSQ shared package
// Sizes, operand encoding and the bundles passed between the
// dispatch side, both queues and the memory port
////////////////////

package lsq_pkg;
	localparam int data_width = 64;
	localparam int tag_width = 6;
	localparam int rob_width = 5;
	localparam int lq_depth = 8;
	localparam int sq_depth = 8;
	localparam int sq_ptr_width = 4;	// Index plus wrap bit
	localparam int addr_width = 32;
	localparam int slot_width = $clog2(lq_depth);

	////////////////////
	// Operands
	////////////////////

	// One word, either a value or a physical register tag
	typedef union packed {
		logic [data_width-1:0] data;
		struct packed {
			logic [data_width-tag_width-1:0] pad;
			logic [tag_width-1:0] tag;
		} reg_ref;
	} opnd_word_t;

	typedef struct packed {
		opnd_word_t word;
		logic ready;	// Low while word holds a tag
	} opnd_t;

	typedef enum logic [1:0] {
		op_none,
		op_load,
		op_store
	} mem_op_t;

	////////////////////
	// Core side buses
	////////////////////

	typedef struct packed {
		logic valid;
		mem_op_t op;
		opnd_t base;
		logic [data_width-1:0] offset;
		opnd_t store_data;
		logic [tag_width-1:0] dest_tag;
		logic [rob_width-1:0] rob_idx;
	} dispatch_t;

	typedef struct packed {
		logic valid;
		logic [tag_width-1:0] tag;
		logic [data_width-1:0] data;
	} bcast_t;

	typedef struct packed {
		logic valid;
		logic [tag_width-1:0] dest_tag;
		logic [data_width-1:0] data;
		logic [rob_width-1:0] rob_idx;
	} result_t;

	////////////////////
	// Queue entries and memory requests
	////////////////////

	typedef struct packed {
		opnd_t base;
		logic [data_width-1:0] offset;
		logic [tag_width-1:0] dest_tag;
		logic [rob_width-1:0] rob_idx;
		logic [sq_ptr_width-1:0] store_mark;	// Store tail when the load came in
	} lq_entry_t;

	typedef struct packed {
		opnd_t base;
		logic [data_width-1:0] offset;
		opnd_t store_data;
		logic [rob_width-1:0] rob_idx;
	} sq_entry_t;

	typedef struct packed {
		logic valid;
		lq_entry_t entry;
	} lq_write_t;

	typedef struct packed {
		logic valid;
		sq_entry_t entry;
	} sq_write_t;

	typedef struct packed {
		logic valid;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic [slot_width-1:0] slot;
	} mem_req_t;

	typedef struct packed {
		logic pulse;
		logic [slot_width-1:0] slot;
	} grant_t;

	typedef struct packed {
		logic [tag_width-1:0] dest_tag;
		logic [rob_width-1:0] rob_idx;
	} ld_meta_t;

	// Capture a broadcast value into a waiting operand
	function automatic opnd_t wake(opnd_t opnd, bcast_t beat);
		opnd_t woken;
		woken = opnd;
		if (!opnd.ready && beat.valid && opnd.word.reg_ref.tag == beat.tag) begin
			woken.word.data = beat.data;
			woken.ready = 1'b1;
		end
		return woken;
	endfunction
endpackage

/* logic/lsq_dispatch.sv */
////////////////////
// LSQ dispatch stage
// Classifies one dispatched operation, picks up a same-cycle
// broadcast for its operands and steers it into a queue
////////////////////

module lsq_dispatch (
	input logic clock,
	input logic reset,
	input lsq_pkg::dispatch_t dispatch,
	input lsq_pkg::bcast_t bcast,
	output logic full,
	input logic lq_full,
	input logic sq_full,
	input logic [lsq_pkg::sq_ptr_width-1:0] sq_tail,
	output lsq_pkg::lq_write_t lq_write,
	output lsq_pkg::sq_write_t sq_write
);
	logic take;
	logic is_load;
	logic is_store;
	lsq_pkg::opnd_t base_now;
	lsq_pkg::opnd_t data_now;

	////////////////////
	// Handshake
	////////////////////

	assign full = lq_full | sq_full;	// Either queue stops all dispatch
	assign take = dispatch.valid & ~full;
	assign is_load = dispatch.op == lsq_pkg::op_load;
	assign is_store = dispatch.op == lsq_pkg::op_store;

	// Bus beat in this cycle counts as already seen
	assign base_now = lsq_pkg::wake(dispatch.base, bcast);
	assign data_now = lsq_pkg::wake(dispatch.store_data, bcast);

	////////////////////
	// Queue write bundles
	////////////////////

	always_comb begin
		lq_write.valid = take & is_load;
		lq_write.entry.base = base_now;
		lq_write.entry.offset = dispatch.offset;
		lq_write.entry.dest_tag = dispatch.dest_tag;
		lq_write.entry.rob_idx = dispatch.rob_idx;
		lq_write.entry.store_mark = sq_tail;	// Older stores end here
	end

	always_comb begin
		sq_write.valid = take & is_store;
		sq_write.entry.base = base_now;
		sq_write.entry.offset = dispatch.offset;
		sq_write.entry.store_data = data_now;
		sq_write.entry.rob_idx = dispatch.rob_idx;
	end
endmodule

/* logic/load_queue.sv */
////////////////////
// Load queue
// Eight load slots with base wakeup, store ordering marks and
// lowest-slot-first selection of the next load for memory
////////////////////

module load_queue (
	input logic clock,
	input logic reset,
	input lsq_pkg::lq_write_t lq_write,
	input lsq_pkg::bcast_t bcast,
	input logic [lsq_pkg::sq_ptr_width-1:0] sq_head,
	output logic lq_full,
	output lsq_pkg::mem_req_t ld_req,
	input lsq_pkg::grant_t ld_grant,
	output lsq_pkg::ld_meta_t ld_meta
);
	lsq_pkg::lq_entry_t slots [lsq_pkg::lq_depth];
	logic [lsq_pkg::lq_depth-1:0] occupied;
	logic [lsq_pkg::lq_depth-1:0] ordered;	// All older stores have been written
	logic [lsq_pkg::lq_depth-1:0] eligible;
	logic [lsq_pkg::slot_width-1:0] free_idx;
	logic [lsq_pkg::slot_width-1:0] pick_idx;
	logic [lsq_pkg::data_width-1:0] pick_sum;

	assign lq_full = &occupied;

	// Lowest free slot takes the next load
	always_comb begin
		free_idx = '0;
		for (int i = lsq_pkg::lq_depth - 1; i >= 0; i--) begin
			if (!occupied[i])
				free_idx = lsq_pkg::slot_width'(i);
		end
	end

	////////////////////
	// Slot state
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			occupied <= '0;
			ordered <= '0;
		end else begin
			for (int i = 0; i < lsq_pkg::lq_depth; i++) begin
				if (occupied[i] && slots[i].store_mark == sq_head)
					ordered[i] <= 1'b1;	// Latched, head moves on later
			end
			if (ld_grant.pulse) begin
				occupied[ld_grant.slot] <= 1'b0;
				ordered[ld_grant.slot] <= 1'b0;
			end
			if (lq_write.valid) begin
				occupied[free_idx] <= 1'b1;
				ordered[free_idx] <= lq_write.entry.store_mark == sq_head;
			end
		end
	end

	// Payload with base wakeup, a new write wins over the wakeup
	always_ff @(posedge clock) begin
		for (int i = 0; i < lsq_pkg::lq_depth; i++)
			slots[i].base <= lsq_pkg::wake(slots[i].base, bcast);
		if (lq_write.valid)
			slots[free_idx] <= lq_write.entry;
	end

	////////////////////
	// Issue select
	////////////////////

	always_comb begin
		for (int i = 0; i < lsq_pkg::lq_depth; i++)
			eligible[i] = occupied[i] & ordered[i] & slots[i].base.ready;
	end

	always_comb begin
		pick_idx = '0;
		for (int i = lsq_pkg::lq_depth - 1; i >= 0; i--) begin
			if (eligible[i])
				pick_idx = lsq_pkg::slot_width'(i);
		end
	end

	assign pick_sum = slots[pick_idx].base.word.data + slots[pick_idx].offset;

	always_comb begin
		ld_req.valid = |eligible;
		ld_req.addr = pick_sum[lsq_pkg::addr_width-1:0];
		ld_req.wdata = '0;
		ld_req.slot = pick_idx;
	end

	// Tag and ROB index of the load being completed
	always_comb begin
		ld_meta.dest_tag = slots[ld_grant.slot].dest_tag;
		ld_meta.rob_idx = slots[ld_grant.slot].rob_idx;
	end
endmodule

/* logic/store_queue.sv */
////////////////////
// Store queue
// Circular store buffer, operand wakeup and in-order
// retirement of the head store to memory
////////////////////

module store_queue (
	input logic clock,
	input logic reset,
	input lsq_pkg::sq_write_t sq_write,
	input lsq_pkg::bcast_t bcast,
	input logic [lsq_pkg::rob_width-1:0] rob_head,
	output logic sq_full,
	output logic [lsq_pkg::sq_ptr_width-1:0] sq_tail,
	output logic [lsq_pkg::sq_ptr_width-1:0] sq_head,
	output lsq_pkg::mem_req_t st_req,
	input logic st_done
);
	localparam int idx_width = lsq_pkg::sq_ptr_width - 1;

	lsq_pkg::sq_entry_t slots [lsq_pkg::sq_depth];
	logic [idx_width-1:0] head_idx;
	logic [idx_width-1:0] tail_idx;
	logic empty;
	logic head_ready;
	lsq_pkg::sq_entry_t head_entry;
	logic [lsq_pkg::data_width-1:0] head_sum;

	assign head_idx = sq_head[idx_width-1:0];
	assign tail_idx = sq_tail[idx_width-1:0];

	////////////////////
	// Pointers
	////////////////////

	// Same index, wrap bits differ
	assign sq_full = head_idx == tail_idx && sq_head[idx_width] != sq_tail[idx_width];
	assign empty = sq_head == sq_tail;

	always_ff @(posedge clock) begin
		if (reset) begin
			sq_head <= '0;
			sq_tail <= '0;
		end else begin
			if (sq_write.valid)
				sq_tail <= sq_tail + 1'b1;
			if (st_done)
				sq_head <= sq_head + 1'b1;	// Head store is now in memory
		end
	end

	////////////////////
	// Entries
	////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < lsq_pkg::sq_depth; i++) begin
			slots[i].base <= lsq_pkg::wake(slots[i].base, bcast);
			slots[i].store_data <= lsq_pkg::wake(slots[i].store_data, bcast);
		end
		if (sq_write.valid)
			slots[tail_idx] <= sq_write.entry;	// Overrides the wakeup above
	end

	////////////////////
	// Head retirement
	////////////////////

	assign head_entry = slots[head_idx];
	assign head_sum = head_entry.base.word.data + head_entry.offset;

	// Both operands known and the ROB has reached this store
	assign head_ready = !empty
		&& head_entry.base.ready
		&& head_entry.store_data.ready
		&& head_entry.rob_idx == rob_head;

	always_comb begin
		st_req.valid = head_ready;
		st_req.addr = head_sum[lsq_pkg::addr_width-1:0];
		st_req.wdata = head_entry.store_data.word.data;
		st_req.slot = head_idx;
	end
endmodule

/* logic/mem_port.sv */
////////////////////
// Memory port
// Runs one Wishbone classic cycle at a time for the store head
// or the selected load, and returns load data on the result port
////////////////////

module mem_port (
	input logic clock,
	input logic reset,
	input lsq_pkg::mem_req_t ld_req,
	input lsq_pkg::mem_req_t st_req,
	input lsq_pkg::ld_meta_t ld_meta,
	output lsq_pkg::grant_t ld_grant,
	output logic st_done,
	output lsq_pkg::result_t result,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [lsq_pkg::addr_width-1:0] wb_adr,
	output logic [lsq_pkg::data_width-1:0] wb_dat_w,
	input logic [lsq_pkg::data_width-1:0] wb_dat_r,
	input logic wb_ack
);
	logic busy;	// Idle when low
	logic accept_store;
	logic accept_load;
	logic load_ack;
	logic [lsq_pkg::slot_width-1:0] slot_q;

	// Stores go first so retirement is never starved
	assign accept_store = !busy && st_req.valid;
	assign accept_load = !busy && !st_req.valid && ld_req.valid;
	assign load_ack = busy && wb_ack && !wb_we;

	assign wb_cyc = busy;
	assign wb_stb = busy;

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			wb_we <= 1'b0;
		end else if (accept_store || accept_load) begin
			busy <= 1'b1;
			wb_we <= accept_store;
		end else if (busy && wb_ack) begin
			busy <= 1'b0;	// cyc and stb drop after the ack edge
			wb_we <= 1'b0;
		end
	end

	// Address and data held for the whole bus cycle
	always_ff @(posedge clock) begin
		if (accept_store) begin
			wb_adr <= st_req.addr;
			wb_dat_w <= st_req.wdata;
		end else if (accept_load) begin
			wb_adr <= ld_req.addr;
			wb_dat_w <= ld_req.wdata;
			slot_q <= ld_req.slot;
		end
	end

	////////////////////
	// Completion
	////////////////////

	assign st_done = busy && wb_ack && wb_we;

	always_comb begin
		ld_grant.pulse = load_ack;
		ld_grant.slot = slot_q;
	end

	always_ff @(posedge clock) begin
		if (reset)
			result.valid <= 1'b0;
		else
			result.valid <= load_ack;	// One cycle, right after the ack
	end

	always_ff @(posedge clock) begin
		if (load_ack) begin
			result.data <= wb_dat_r;
			result.dest_tag <= ld_meta.dest_tag;
			result.rob_idx <= ld_meta.rob_idx;
		end
	end
endmodule

/* logic/lsq_top.sv */
////////////////////
// Load/store queue top
// Dispatch side, load and store queues and the Wishbone port
////////////////////

module lsq_top (
	input logic clock,
	input logic reset,
	input lsq_pkg::dispatch_t dispatch,
	input lsq_pkg::bcast_t bcast,
	input logic [lsq_pkg::rob_width-1:0] rob_head,
	output logic full,
	output lsq_pkg::result_t result,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [lsq_pkg::addr_width-1:0] wb_adr,
	output logic [lsq_pkg::data_width-1:0] wb_dat_w,
	input logic [lsq_pkg::data_width-1:0] wb_dat_r,
	input logic wb_ack
);
	lsq_pkg::lq_write_t lq_write;
	lsq_pkg::sq_write_t sq_write;
	lsq_pkg::mem_req_t ld_req;
	lsq_pkg::mem_req_t st_req;
	lsq_pkg::grant_t ld_grant;
	lsq_pkg::ld_meta_t ld_meta;
	logic lq_full;
	logic sq_full;
	logic st_done;
	logic [lsq_pkg::sq_ptr_width-1:0] sq_tail;
	logic [lsq_pkg::sq_ptr_width-1:0] sq_head;

	lsq_dispatch u_dispatch (
		.clock(clock), .reset(reset), .dispatch(dispatch), .bcast(bcast), .full(full),
		.lq_full(lq_full), .sq_full(sq_full), .sq_tail(sq_tail),
		.lq_write(lq_write), .sq_write(sq_write)
	);

	load_queue u_load_queue (
		.clock(clock), .reset(reset), .lq_write(lq_write), .bcast(bcast),
		.sq_head(sq_head), .lq_full(lq_full), .ld_req(ld_req),
		.ld_grant(ld_grant), .ld_meta(ld_meta)
	);

	store_queue u_store_queue (
		.clock(clock), .reset(reset), .sq_write(sq_write), .bcast(bcast),
		.rob_head(rob_head), .sq_full(sq_full), .sq_tail(sq_tail), .sq_head(sq_head),
		.st_req(st_req), .st_done(st_done)
	);

	mem_port u_mem_port (
		.clock(clock), .reset(reset), .ld_req(ld_req), .st_req(st_req), .ld_meta(ld_meta),
		.ld_grant(ld_grant), .st_done(st_done), .result(result),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);
endmodule

/* testbench/lsq_model.svh */
////////////////////
// LSQ reference model
// Memory with stores applied in program order, ROB order and
// the expected result of every load in flight
////////////////////

`ifndef LSQ_MODEL_SVH
`define LSQ_MODEL_SVH

typedef struct packed {
	logic [lsq_pkg::addr_width-1:0] addr;
	logic [lsq_pkg::data_width-1:0] data;
	logic [lsq_pkg::rob_width-1:0] rob_idx;
} store_rec_t;

logic [lsq_pkg::data_width-1:0] model_mem [mem_words];
store_rec_t store_order [$];	// Oldest first, bus writes must follow it
logic [lsq_pkg::rob_width-1:0] rob_order [$];	// Taken ops in program order
logic rob_done [1 << lsq_pkg::rob_width];
logic load_live [1 << lsq_pkg::tag_width];
logic [lsq_pkg::data_width-1:0] load_data [1 << lsq_pkg::tag_width];
logic [lsq_pkg::rob_width-1:0] load_rob [1 << lsq_pkg::tag_width];

// Start value of each word, built from all address bits
function automatic logic [lsq_pkg::data_width-1:0] fill_word(int unsigned a);
	return {a * 32'h9e37_79b9, ~a ^ 32'h5a5a_0000};
endfunction

task automatic model_reset();
	for (int i = 0; i < mem_words; i++)
		model_mem[i] = fill_word(i);
	for (int i = 0; i < (1 << lsq_pkg::rob_width); i++)
		rob_done[i] = 1'b0;
	for (int i = 0; i < (1 << lsq_pkg::tag_width); i++)
		load_live[i] = 1'b0;
	store_order.delete();
	rob_order.delete();
endtask

// A load sees every store taken before it
task automatic model_accept(
	input lsq_pkg::mem_op_t op,
	input logic [lsq_pkg::addr_width-1:0] addr,
	input logic [lsq_pkg::data_width-1:0] data,
	input logic [lsq_pkg::tag_width-1:0] tag,
	input logic [lsq_pkg::rob_width-1:0] rob
);
	store_rec_t st;
	rob_order.push_back(rob);
	rob_done[rob] = 1'b0;
	if (op == lsq_pkg::op_store) begin
		model_mem[addr % mem_words] = data;
		st.addr = addr;
		st.data = data;
		st.rob_idx = rob;
		store_order.push_back(st);
	end else begin
		load_live[tag] = 1'b1;
		load_data[tag] = model_mem[addr % mem_words];
		load_rob[tag] = rob;
	end
endtask

function automatic lsq_pkg::result_t expected_result(input logic [lsq_pkg::tag_width-1:0] tag);
	lsq_pkg::result_t exp;
	exp.valid = 1'b1;
	exp.dest_tag = tag;
	exp.data = load_data[tag];
	exp.rob_idx = load_rob[tag];
	return exp;
endfunction

task automatic model_load_done(input logic [lsq_pkg::tag_width-1:0] tag);
	load_live[tag] = 1'b0;
	rob_done[load_rob[tag]] = 1'b1;
endtask

// Retire in order, the head is the oldest op not yet complete
task automatic retire_done();
	while (rob_order.size() > 0 && rob_done[rob_order[0]])
		void'(rob_order.pop_front());
endtask

`endif

/* testbench/lsq_tb.sv */
////////////////////
// LSQ testbench
// Random loads and stores against a Wishbone memory slave,
// checked against the reference model
////////////////////

module lsq_tb;
	localparam int n_ops = 300;
	localparam int mem_words = 256;
	localparam int addr_span = 16;	// Small range so loads hit older stores
	localparam int ack_max = 3;
	localparam int period = 40;

	logic clock;
	logic reset;
	lsq_pkg::dispatch_t dispatch;
	lsq_pkg::bcast_t bcast;
	logic [lsq_pkg::rob_width-1:0] rob_head;
	logic full;
	lsq_pkg::result_t result;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [lsq_pkg::addr_width-1:0] wb_adr;
	logic [lsq_pkg::data_width-1:0] wb_dat_w;
	logic [lsq_pkg::data_width-1:0] wb_dat_r;
	logic wb_ack;

	integer seed = 49;
	logic running;
	logic all_done;
	logic full_seen;
	int gen_count;
	int taken_count;
	int ack_wait;
	int lq_count;	// Loads holding a slot
	int sq_count;	// Stores not yet written
	logic [lsq_pkg::rob_width-1:0] next_rob;	// Index of the op being presented
	logic [lsq_pkg::tag_width-1:0] dest_ctr;
	logic [lsq_pkg::tag_width-1:0] tag_ctr;
	logic tag_busy [1 << lsq_pkg::tag_width];
	lsq_pkg::bcast_t beat_q [$];	// Wakeups still to send in order
	logic [lsq_pkg::addr_width-1:0] cur_addr;
	logic [lsq_pkg::data_width-1:0] cur_data;
	logic [lsq_pkg::data_width-1:0] mem [mem_words];

	`include "lsq_model.svh"

	lsq_top u_dut (
		.clock(clock), .reset(reset), .dispatch(dispatch), .bcast(bcast),
		.rob_head(rob_head), .full(full), .result(result),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		#(n_ops * 20 * period);
		$display("Watchdog expired before all operations completed");
		end_with_failure();
	end

	////////////////////
	// Checks
	////////////////////

	task automatic end_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_result(string name, lsq_pkg::result_t exp, lsq_pkg::result_t act);
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_word(string name, logic [lsq_pkg::data_width-1:0] exp,
			logic [lsq_pkg::data_width-1:0] act);
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			end_with_failure();
		end
	endtask

	////////////////////
	// Core side
	////////////////////

	// Either a value or a fresh tag whose value is broadcast later
	task automatic make_opnd(input logic [lsq_pkg::data_width-1:0] value,
			output lsq_pkg::opnd_t opnd);
		lsq_pkg::bcast_t beat;
		opnd.word.data = value;
		opnd.ready = 1'b1;
		if ($unsigned($random(seed)) % 3 == 0) begin
			while (tag_busy[tag_ctr])
				tag_ctr++;
			tag_busy[tag_ctr] = 1'b1;
			opnd.word.data = '0;
			opnd.word.reg_ref.tag = tag_ctr;
			opnd.ready = 1'b0;
			beat.valid = 1'b1;
			beat.tag = tag_ctr;
			beat.data = value;
			beat_q.push_back(beat);
			tag_ctr++;
		end
	endtask

	task automatic present_next();
		lsq_pkg::dispatch_t d;
		logic [lsq_pkg::data_width-1:0] base_val;
		logic [lsq_pkg::data_width-1:0] off;
		d = '0;
		base_val = $unsigned($random(seed)) % addr_span;
		off = $unsigned($random(seed)) % addr_span;
		cur_addr = lsq_pkg::addr_width'(base_val + off);
		cur_data = {$random(seed), $random(seed)};
		d.valid = 1'b1;
		d.op = ($random(seed) & 1) ? lsq_pkg::op_store : lsq_pkg::op_load;
		d.offset = off;
		make_opnd(base_val, d.base);
		if (d.op == lsq_pkg::op_store)
			make_opnd(cur_data, d.store_data);
		else
			d.store_data.ready = 1'b1;
		d.dest_tag = dest_ctr;
		dest_ctr++;
		d.rob_idx = next_rob;
		gen_count++;
		dispatch <= d;
	endtask

	// Held dispatch catches beats on the bus like the core would
	task automatic hold_wakeup();
		lsq_pkg::dispatch_t d;
		d = dispatch;
		if (bcast.valid && !d.base.ready && d.base.word.reg_ref.tag == bcast.tag) begin
			d.base.word.data = bcast.data;
			d.base.ready = 1'b1;
		end
		if (bcast.valid && !d.store_data.ready
				&& d.store_data.word.reg_ref.tag == bcast.tag) begin
			d.store_data.word.data = bcast.data;
			d.store_data.ready = 1'b1;
		end
		dispatch <= d;
	endtask

	task automatic send_beat();
		lsq_pkg::bcast_t beat;
		beat = '0;
		if (beat_q.size() > 0 && ($random(seed) & 1)) begin
			beat = beat_q.pop_front();
			tag_busy[beat.tag] = 1'b0;	// Reusable from the next cycle
		end
		bcast <= beat;
	endtask

	task automatic take_result();
		if (!load_live[result.dest_tag]) begin
			$display("Result for destination tag %0d with no load in flight", result.dest_tag);
			end_with_failure();
		end
		check_result("load result", expected_result(result.dest_tag), result);
		model_load_done(result.dest_tag);
		lq_count--;	// Slot freed with the ack edge
	endtask

	////////////////////
	// Wishbone memory slave
	////////////////////

	task automatic serve_bus();
		store_rec_t st;
		if (wb_cyc && wb_stb && !wb_ack) begin
			if (ack_wait == 0) begin
				wb_ack <= 1'b1;
				if (wb_we) begin
					if (store_order.size() == 0) begin
						$display("Wishbone write with no store outstanding");
						end_with_failure();
					end
					st = store_order.pop_front();
					if (rob_head !== st.rob_idx) begin
						$display("Store %0d written while the ROB head was %0d",
							st.rob_idx, rob_head);
						end_with_failure();
					end
					check_word("store address", 64'(st.addr), 64'(wb_adr));
					check_word("store data", st.data, wb_dat_w);
					mem[wb_adr % mem_words] <= wb_dat_w;
					rob_done[st.rob_idx] = 1'b1;
				end else begin
					wb_dat_r <= mem[wb_adr % mem_words];
				end
			end else begin
				ack_wait--;
			end
		end else begin
			if (wb_ack && wb_we)
				sq_count--;	// Head slot frees on this edge
			wb_ack <= 1'b0;
			ack_wait = $unsigned($random(seed)) % (ack_max + 1);
		end
	endtask

	always @(posedge clock) begin
		if (running) begin
			if (result.valid)
				take_result();
			// Occupancy during the cycle that just ended
			check_flag("full flag",
				lq_count == lsq_pkg::lq_depth || sq_count == lsq_pkg::sq_depth, full);
			serve_bus();
			full_seen = full_seen | full;
			if (dispatch.valid && !full) begin
				model_accept(dispatch.op, cur_addr, cur_data, dispatch.dest_tag,
					dispatch.rob_idx);
				if (dispatch.op == lsq_pkg::op_store)
					sq_count++;
				else
					lq_count++;
				next_rob++;
				taken_count++;
			end else if (dispatch.valid) begin
				hold_wakeup();
			end
			retire_done();
			rob_head <= rob_order.size() > 0 ? rob_order[0] : next_rob;
			if (!dispatch.valid || !full) begin
				if (gen_count < n_ops && $unsigned($random(seed)) % 4 != 0)
					present_next();
				else
					dispatch.valid <= 1'b0;
			end
			send_beat();	// After present_next so a beat can meet its own dispatch
			all_done <= taken_count == n_ops && rob_order.size() == 0;
		end
	end

	initial begin
		reset = 1'b1;
		dispatch = '0;
		bcast = '0;
		rob_head = '0;
		wb_dat_r = '0;
		wb_ack = 1'b0;
		running = 1'b0;
		all_done = 1'b0;
		full_seen = 1'b0;
		gen_count = 0;
		taken_count = 0;
		ack_wait = 0;
		lq_count = 0;
		sq_count = 0;
		next_rob = '0;
		dest_ctr = '0;
		tag_ctr = '0;
		model_reset();
		for (int i = 0; i < mem_words; i++)
			mem[i] = fill_word(i);
		for (int i = 0; i < (1 << lsq_pkg::tag_width); i++)
			tag_busy[i] = 1'b0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		// Quiet outputs until the first dispatch
		repeat (3) begin
			@(posedge clock);
			check_flag("reset full", 1'b0, full);
			check_flag("reset result valid", 1'b0, result.valid);
			check_flag("reset wb_cyc", 1'b0, wb_cyc);
			check_flag("reset wb_stb", 1'b0, wb_stb);
			check_flag("reset wb_we", 1'b0, wb_we);
		end
		running <= 1'b1;
		wait (all_done);
		@(posedge clock);
		for (int i = 0; i < mem_words; i++)
			check_word("final memory", model_mem[i], mem[i]);
		if (!full_seen) begin
			$display("Full flag never rose during the run");
			end_with_failure();
		end else begin
			$display("Test passed");
			$finish;
		end
	end
endmodule

/* project.f */
+incdir+testbench
logic/lsq_pkg.sv
logic/lsq_dispatch.sv
logic/load_queue.sv
logic/store_queue.sv
logic/mem_port.sv
logic/lsq_top.sv
testbench/lsq_tb.sv
